// ==== dv/frontend_tb.sv ====
module frontend_tb;
    import bp_pkg::*;

    // Upper bound on the run length in clock cycles
    localparam int MAX_CYCLES = 2000;
    // Far away jump that only steers fetch and sits at BTB index 0
    localparam logic [31:0] STEER_PC = 32'h8000_0000;

    logic         clk;
    logic         rst;
    logic         credit_i;
    logic         resolve_valid_i;
    logic [31:0]  resolve_pc_i;
    branch_kind_e resolve_kind_i;
    logic         resolve_taken_i;
    logic [31:0]  resolve_target_i;
    logic         resolve_pred_taken_i;
    logic [31:0]  resolve_pred_target_i;
    logic         fetch_valid_o;
    logic [31:0]  fetch_pc_o;
    logic         fetch_pred_taken_o;
    logic [31:0]  fetch_pred_target_o;
    logic         mispredict_o;
    logic [31:0]  redirect_pc_o;

    // Reference copy of the BTB and the counter table
    logic         m_valid  [BTB_ENTRIES];
    logic [25:0]  m_tag    [BTB_ENTRIES];
    logic [31:0]  m_target [BTB_ENTRIES];
    branch_kind_e m_kind   [BTB_ENTRIES];
    logic [1:0]   m_ctr    [PHT_ENTRIES];

    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    logic [31:0] rng = 32'h3f3dd7bc;
    logic [31:0] br_pc;
    logic [31:0] br_tgt;
    logic [31:0] redir_target;
    logic        redir_taken;
    logic        auto_credit;
    int          owed;
    int          pkt_count;
    int          cycle_count;
    string       cur_test;

    frontend_top dut_i (
        .clk_i                 ( clk                   ),
        .rst_i                 ( rst                   ),
        .credit_i              ( credit_i              ),
        .resolve_valid_i       ( resolve_valid_i       ),
        .resolve_pc_i          ( resolve_pc_i          ),
        .resolve_kind_i        ( resolve_kind_i        ),
        .resolve_taken_i       ( resolve_taken_i       ),
        .resolve_target_i      ( resolve_target_i      ),
        .resolve_pred_taken_i  ( resolve_pred_taken_i  ),
        .resolve_pred_target_i ( resolve_pred_target_i ),
        .fetch_valid_o         ( fetch_valid_o         ),
        .fetch_pc_o            ( fetch_pc_o            ),
        .fetch_pred_taken_o    ( fetch_pred_taken_o    ),
        .fetch_pred_target_o   ( fetch_pred_target_o   ),
        .mispredict_o          ( mispredict_o          ),
        .redirect_pc_o         ( redirect_pc_o         )
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // --------------------------------------------------
    // Helpers and reference model
    // --------------------------------------------------

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s: %s expected %h actual %h", cur_test, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // Hit needs a valid entry with a matching tag (PC bits 31..6)
    function automatic logic predict_taken(input logic [31:0] pc);
        logic hit;
        hit = m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[31:6]);
        return hit && ((m_kind[pc[5:2]] == KIND_JUMP) || m_ctr[pc[7:2]][1]);
    endfunction

    function automatic logic [31:0] predict_target(input logic [31:0] pc);
        return predict_taken(pc) ? m_target[pc[5:2]] : pc + 32'd4;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        // Every counter starts weakly not taken
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_ctr[i] = 2'd1;
        end
    endtask

    task automatic model_train(input logic [31:0] pc, input branch_kind_e kind,
                               input logic taken, input logic [31:0] target);
        if (taken) begin
            m_valid[pc[5:2]]  = 1'b1;
            m_tag[pc[5:2]]    = pc[31:6];
            m_target[pc[5:2]] = target;
            m_kind[pc[5:2]]   = kind;
        end
        if (kind == KIND_COND) begin
            if (taken && m_ctr[pc[7:2]] != 2'd3) begin
                m_ctr[pc[7:2]] = m_ctr[pc[7:2]] + 2'd1;
            end else if (!taken && m_ctr[pc[7:2]] != 2'd0) begin
                m_ctr[pc[7:2]] = m_ctr[pc[7:2]] - 2'd1;
            end
        end
    endtask

    // --------------------------------------------------
    // Monitor, credit return and timeout
    // --------------------------------------------------

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (!rst && fetch_valid_o) begin
            check_value("fetch pc", exp_pc, fetch_pc_o);
            check_value("pred taken", predict_taken(exp_pc), fetch_pred_taken_o);
            check_value("pred target", predict_target(exp_pc), fetch_pred_target_o);
            exp_pc = predict_target(exp_pc);
            last_pc = fetch_pc_o;
            pkt_count++;
            owed++;
        end
    end

    // The queue frees one slot per cycle for every packet it holds
    always @(posedge clk) begin
        #1;
        if (auto_credit) begin
            if (!rst && owed > 0) begin
                credit_i = 1'b1;
                owed--;
            end else begin
                credit_i = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("error: timeout after %0d cycles, fetch never reached the awaited state",
                     cycle_count);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        credit_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        model_reset();
        exp_pc = RESET_PC;
        owed = 0;
    endtask

    // One resolution, checked against the misprediction rule and trained into the model
    task automatic resolve_branch(input logic [31:0] pc, input branch_kind_e kind,
                                  input logic taken, input logic [31:0] target,
                                  input logic p_taken, input logic [31:0] p_target);
        logic        act;
        logic        mp;
        logic [31:0] rpc;
        act = taken || (kind == KIND_JUMP);
        mp  = (act != p_taken) || (act && (target != p_target));
        rpc = act ? target : pc + 32'd4;
        @(posedge clk);
        #1;
        resolve_valid_i       = 1'b1;
        resolve_pc_i          = pc;
        resolve_kind_i        = kind;
        resolve_taken_i       = act;
        resolve_target_i      = target;
        resolve_pred_taken_i  = p_taken;
        resolve_pred_target_i = p_target;
        if (mp) begin
            exp_pc = rpc;
        end
        @(negedge clk);
        check_value("mispredict", mp, mispredict_o);
        if (mp) begin
            check_value("redirect pc", rpc, redirect_pc_o);
        end
        @(posedge clk);
        model_train(pc, kind, act, target);
        #1;
        resolve_valid_i = 1'b0;
        // First fetch at the redirect PC comes exactly one cycle later
        if (mp) begin
            @(negedge clk);
            check_value("fetch valid after redirect", 1'b1, fetch_valid_o);
            check_value("fetch pc after redirect", rpc, fetch_pc_o);
            redir_taken  = fetch_pred_taken_o;
            redir_target = fetch_pred_target_o;
        end
    endtask

    task automatic steer_fetch(input logic [31:0] pc);
        resolve_branch(STEER_PC, KIND_JUMP, 1'b1, pc, 1'b0, STEER_PC + 32'd4);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset_fetch();
        int k;
        cur_test = "reset_fetch";
        @(negedge clk);
        check_value("mispredict after reset", 1'b0, mispredict_o);
        for (k = 0; k < 6; k++) begin
            while (!fetch_valid_o) @(negedge clk);
            check_value("sequential pc", RESET_PC + 32'(4 * k), fetch_pc_o);
            check_value("sequential taken", 1'b0, fetch_pred_taken_o);
            check_value("sequential target", RESET_PC + 32'(4 * k + 4), fetch_pred_target_o);
            @(negedge clk);
        end
    endtask

    task automatic test_credit_backpressure();
        int base;
        cur_test = "credit_backpressure";
        auto_credit = 1'b0;
        apply_reset();
        base = pkt_count;
        repeat (10) @(negedge clk);
        check_value("packets with credit withheld", FETCH_CREDITS, pkt_count - base);
        repeat (3) begin
            @(negedge clk);
            check_value("valid while stalled", 1'b0, fetch_valid_o);
            check_value("held pc", RESET_PC + 32'(4 * FETCH_CREDITS), fetch_pc_o);
        end
        @(posedge clk);
        #1;
        credit_i = 1'b1;
        owed--;
        @(posedge clk);
        #1;
        credit_i = 1'b0;
        base = pkt_count;
        repeat (6) @(negedge clk);
        check_value("packets after one credit", 1, pkt_count - base);
        check_value("released pc", RESET_PC + 32'(4 * FETCH_CREDITS), last_pc);
        auto_credit = 1'b1;
    endtask

    task automatic test_cond_training();
        logic [31:0] r;
        logic [3:0]  idx;
        cur_test = "cond_training";
        next_rand(r);
        // Index 0 belongs to the steering jump
        idx = 4'((r % 15) + 1);
        br_pc = {r[31:6], idx, 2'b00};
        next_rand(r);
        br_tgt = {r[31:2], 2'b00};
        steer_fetch(br_pc);
        check_value("cold taken", 1'b0, redir_taken);
        check_value("cold target", br_pc + 32'd4, redir_target);
        resolve_branch(br_pc, KIND_COND, 1'b1, br_tgt, 1'b0, br_pc + 32'd4);
        steer_fetch(br_pc);
        check_value("trained taken", predict_taken(br_pc), redir_taken);
        check_value("trained target", br_tgt, redir_target);
    endtask

    task automatic test_jump_prediction();
        logic [31:0] r;
        logic [31:0] jp;
        logic [31:0] jt;
        int          ji;
        cur_test = "jump_prediction";
        next_rand(r);
        // Keep clear of the conditional branch entry used by later tests
        ji = (int'(br_pc[5:2]) % 15) + 1;
        jp = {r[31:6], ji[3:0], 2'b00};
        next_rand(r);
        jt = {r[31:2], 2'b00};
        resolve_branch(jp, KIND_JUMP, 1'b1, jt, 1'b0, jp + 32'd4);
        repeat (3) begin
            resolve_branch(jp, KIND_COND, 1'b0, jt, 1'b0, jp + 32'd4);
        end
        steer_fetch(jp);
        check_value("jump taken", 1'b1, redir_taken);
        check_value("jump target", jt, redir_target);
    endtask

    task automatic test_unlearning();
        cur_test = "unlearning";
        // The counter enters weakly taken and a correct taken resolution saturates it
        resolve_branch(br_pc, KIND_COND, 1'b1, br_tgt, 1'b1, br_tgt);
        // One step down from strongly taken still predicts taken
        resolve_branch(br_pc, KIND_COND, 1'b0, br_tgt, 1'b1, br_tgt);
        steer_fetch(br_pc);
        check_value("taken after one step down", 1'b1, redir_taken);
        check_value("target after one step down", br_tgt, redir_target);
        // The second step crosses into the lower half
        resolve_branch(br_pc, KIND_COND, 1'b0, br_tgt, 1'b1, br_tgt);
        steer_fetch(br_pc);
        check_value("unlearned taken", 1'b0, redir_taken);
        check_value("unlearned target", br_pc + 32'd4, redir_target);
    endtask

    task automatic test_aliasing();
        logic [31:0] r;
        logic [31:0] alias_pc;
        logic [31:0] alias_tgt;
        cur_test = "aliasing";
        alias_pc = br_pc ^ 32'h0040_0000;
        next_rand(r);
        alias_tgt = {r[31:2], 2'b00};
        resolve_branch(alias_pc, KIND_COND, 1'b1, alias_tgt,
                       predict_taken(alias_pc), predict_target(alias_pc));
        steer_fetch(br_pc);
        check_value("evicted taken", 1'b0, redir_taken);
        check_value("evicted target", br_pc + 32'd4, redir_target);
        steer_fetch(alias_pc);
        check_value("alias taken", predict_taken(alias_pc), redir_taken);
        check_value("alias target", predict_target(alias_pc), redir_target);
    endtask

    initial begin
        rst = 1'b1;
        credit_i = 1'b0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_kind_i = KIND_COND;
        resolve_taken_i = 1'b0;
        resolve_target_i = '0;
        resolve_pred_taken_i = 1'b0;
        resolve_pred_target_i = '0;
        auto_credit = 1'b1;
        owed = 0;
        pkt_count = 0;
        cycle_count = 0;
        cur_test = "reset";
        model_reset();
        exp_pc = RESET_PC;
        apply_reset();
        test_reset_fetch();
        test_credit_backpressure();
        test_cond_training();
        test_jump_prediction();
        test_unlearning();
        test_aliasing();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== rtl/bp_fetch_if.sv ====
interface bp_fetch_if;
    import bp_pkg::*;

    // Address the PC generator is fetching in this cycle
    logic [ADDR_W-1:0] lookup_pc;

    // Prediction for that address, valid in the same cycle
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_target;

    // Misprediction redirect coming back from the resolve side
    logic              redirect_valid;
    logic [ADDR_W-1:0] redirect_pc;

    // PC generator side
    modport fetch (
        output lookup_pc,
        input  pred_taken, pred_target, redirect_valid, redirect_pc
    );

    // Predictor side
    modport predictor (
        input  lookup_pc,
        output pred_taken, pred_target, redirect_valid, redirect_pc
    );

endinterface

// ==== rtl/bp_pkg.sv ====
package bp_pkg;

    // --------------------------------------------------
    // Address and table geometry
    // --------------------------------------------------

    // Width of every PC and target
    localparam int ADDR_W = 32;

    // Instructions are word aligned, so bits 1..0 never index a table
    localparam logic [ADDR_W-1:0] INSTR_BYTES = 32'd4;

    // Direct-mapped BTB, indexed by PC bits 5..2 and tagged by bits 31..6
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = ADDR_W - BTB_IDX_W - 2;

    // Counter table, indexed by PC bits 7..2
    localparam int PHT_ENTRIES = 64;
    localparam int PHT_IDX_W   = $clog2(PHT_ENTRIES);

    // First fetch address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

    // Slots the instruction queue grants after reset
    localparam int FETCH_CREDITS = 4;
    localparam int CREDIT_W      = $clog2(FETCH_CREDITS + 1);

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    // Kind of the resolved control transfer
    typedef enum logic {
        KIND_COND = 1'b0,
        KIND_JUMP = 1'b1
    } branch_kind_e;

    // Two-bit saturating counter whose MSB is the predicted direction
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_state_e;

    // Field extraction shared by lookup and training
    function automatic logic [BTB_IDX_W-1:0] btb_index(input logic [ADDR_W-1:0] pc);
        return pc[BTB_IDX_W+1:2];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [ADDR_W-1:0] pc);
        return pc[ADDR_W-1:BTB_IDX_W+2];
    endfunction

    function automatic logic [PHT_IDX_W-1:0] pht_index(input logic [ADDR_W-1:0] pc);
        return pc[PHT_IDX_W+1:2];
    endfunction

endpackage

// ==== rtl/bp_update_if.sv ====
interface bp_update_if;
    import bp_pkg::*;

    // One training write per cycle, broadcast to both tables
    logic              upd_valid;
    logic [ADDR_W-1:0] upd_pc;
    logic [ADDR_W-1:0] upd_target;
    // Actual direction, already forced high for jumps
    logic              upd_taken;
    branch_kind_e      upd_kind;

    // Driven by the predictor
    modport source (
        output upd_valid, upd_pc, upd_target, upd_taken, upd_kind
    );

    // Consumed by the BTB and by the counter table
    modport tbl (
        input  upd_valid, upd_pc, upd_target, upd_taken, upd_kind
    );

endinterface

// ==== rtl/branch_predictor.sv ====
module branch_predictor (
    input  logic                      clk_i,
    input  logic                      rst_i,
    bp_fetch_if.predictor             fetch,
    input  logic                      resolve_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_pc_i,
    input  bp_pkg::branch_kind_e      resolve_kind_i,
    input  logic                      resolve_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_target_i,
    input  logic                      resolve_pred_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_pred_target_i,
    output logic                      mispredict_o
);
    import bp_pkg::*;

    bp_update_if upd_if ();

    logic              btb_hit;
    logic [ADDR_W-1:0] btb_target;
    branch_kind_e      btb_kind;
    logic              pht_taken;
    logic              actual_taken;

    // --------------------------------------------------
    // Tables
    // --------------------------------------------------

    branch_target_buffer btb_unit (
        .clk_i       ( clk_i           ),
        .rst_i       ( rst_i           ),
        .lookup_pc_i ( fetch.lookup_pc ),
        .upd         ( upd_if          ),
        .hit_o       ( btb_hit         ),
        .target_o    ( btb_target      ),
        .kind_o      ( btb_kind        )
    );

    predictor_unit pht_unit (
        .clk_i       ( clk_i           ),
        .rst_i       ( rst_i           ),
        .lookup_pc_i ( fetch.lookup_pc ),
        .upd         ( upd_if          ),
        .taken_o     ( pht_taken       )
    );

    // --------------------------------------------------
    // Prediction
    // --------------------------------------------------

    // Without a BTB hit there is no target, so fall through regardless of the counter
    assign fetch.pred_taken  = btb_hit && ((btb_kind == KIND_JUMP) || pht_taken);
    assign fetch.pred_target = fetch.pred_taken ? btb_target
                                                : fetch.lookup_pc + INSTR_BYTES;

    // --------------------------------------------------
    // Resolution check and training
    // --------------------------------------------------

    assign actual_taken = resolve_taken_i || (resolve_kind_i == KIND_JUMP);

    // Wrong direction, or right direction with a stale target
    assign mispredict_o = resolve_valid_i &&
                          ((actual_taken != resolve_pred_taken_i) ||
                           (actual_taken && (resolve_target_i != resolve_pred_target_i)));

    assign fetch.redirect_valid = mispredict_o;
    assign fetch.redirect_pc    = actual_taken ? resolve_target_i
                                               : resolve_pc_i + INSTR_BYTES;

    // Every resolution becomes exactly one training write
    assign upd_if.upd_valid  = resolve_valid_i;
    assign upd_if.upd_pc     = resolve_pc_i;
    assign upd_if.upd_target = resolve_target_i;
    assign upd_if.upd_taken  = actual_taken;
    assign upd_if.upd_kind   = resolve_kind_i;

    // The execution unit must always report jumps as taken
    a_jump_taken: assert property (
        @(posedge clk_i) disable iff (rst_i)
        resolve_valid_i && (resolve_kind_i == KIND_JUMP) |-> resolve_taken_i
    );

endmodule

// ==== rtl/branch_target_buffer.sv ====
module branch_target_buffer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [bp_pkg::ADDR_W-1:0] lookup_pc_i,
    bp_update_if.tbl                  upd,
    output logic                      hit_o,
    output logic [bp_pkg::ADDR_W-1:0] target_o,
    output bp_pkg::branch_kind_e      kind_o
);
    import bp_pkg::*;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    // One valid bit per entry
    logic [BTB_ENTRIES-1:0] valid_q;

    // Payload arrays that mean something only where the valid bit is set
    logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRIES];
    logic [ADDR_W-1:0]    target_q [BTB_ENTRIES];
    branch_kind_e         kind_q   [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] lk_idx;
    logic [BTB_TAG_W-1:0] lk_tag;
    logic [BTB_IDX_W-1:0] upd_idx;
    logic                 alloc;

    // --------------------------------------------------
    // Lookup
    // --------------------------------------------------

    assign lk_idx = btb_index(lookup_pc_i);
    assign lk_tag = btb_tag(lookup_pc_i);

    // A hit needs a live entry whose tag belongs to this PC
    assign hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target_o = target_q[lk_idx];
    assign kind_o   = kind_q[lk_idx];

    // --------------------------------------------------
    // Allocation
    // --------------------------------------------------

    // Only taken transfers get an entry and simply evict the old occupant
    assign upd_idx = btb_index(upd.upd_pc);
    assign alloc   = upd.upd_valid && upd.upd_taken;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_q[upd_idx]    <= btb_tag(upd.upd_pc);
            target_q[upd_idx] <= upd.upd_target;
            kind_q[upd_idx]   <= upd.upd_kind;
        end
    end

endmodule

// ==== rtl/fetch_pc_gen.sv ====
module fetch_pc_gen (
    input  logic                      clk_i,
    input  logic                      rst_i,
    bp_fetch_if.fetch                 fetch,
    input  logic                      credit_i,
    output logic                      fetch_valid_o,
    output logic [bp_pkg::ADDR_W-1:0] fetch_pc_o,
    output logic                      fetch_pred_taken_o,
    output logic [bp_pkg::ADDR_W-1:0] fetch_pred_target_o
);
    import bp_pkg::*;

    logic [ADDR_W-1:0]   pc_q;
    logic [ADDR_W-1:0]   pc_d;
    logic [CREDIT_W-1:0] credit_q;
    logic [CREDIT_W-1:0] credit_d;

    // --------------------------------------------------
    // Fetch packet
    // --------------------------------------------------

    // The current PC drives the lookup and the prediction returns in the same cycle
    assign fetch.lookup_pc = pc_q;

    // A redirect squashes this cycle so that the wrong-path PC never leaves
    assign fetch_valid_o = (credit_q != '0) && !fetch.redirect_valid;

    assign fetch_pc_o          = pc_q;
    assign fetch_pred_taken_o  = fetch.pred_taken;
    assign fetch_pred_target_o = fetch.pred_target;

    // --------------------------------------------------
    // Next PC and credit accounting
    // --------------------------------------------------

    always_comb begin
        pc_d = pc_q;
        if (fetch.redirect_valid) begin
            pc_d = fetch.redirect_pc;
        end else if (fetch_valid_o) begin
            pc_d = fetch.pred_target;
        end
    end

    // Returned and spent credits may land in the same cycle and cancel out
    assign credit_d = credit_q + CREDIT_W'(credit_i) - CREDIT_W'(fetch_valid_o);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q     <= RESET_PC;
            credit_q <= CREDIT_W'(FETCH_CREDITS);
        end else begin
            pc_q     <= pc_d;
            credit_q <= credit_d;
        end
    end

    // --------------------------------------------------
    // Protocol checks
    // --------------------------------------------------

    a_credit_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        credit_q <= CREDIT_W'(FETCH_CREDITS)
    );

    // The consumer cannot free a slot it was never given
    a_no_credit_when_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        credit_i |-> credit_q < CREDIT_W'(FETCH_CREDITS)
    );

endmodule

// ==== rtl/frontend_top.sv ====
module frontend_top (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Credit return from the instruction queue
    input  logic                      credit_i,

    // Resolved branch from the execution unit, with its attached prediction
    input  logic                      resolve_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_pc_i,
    input  bp_pkg::branch_kind_e      resolve_kind_i,
    input  logic                      resolve_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_target_i,
    input  logic                      resolve_pred_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0] resolve_pred_target_i,

    // Fetch packet toward the instruction queue
    output logic                      fetch_valid_o,
    output logic [bp_pkg::ADDR_W-1:0] fetch_pc_o,
    output logic                      fetch_pred_taken_o,
    output logic [bp_pkg::ADDR_W-1:0] fetch_pred_target_o,

    // Redirect seen by the rest of the core
    output logic                      mispredict_o,
    output logic [bp_pkg::ADDR_W-1:0] redirect_pc_o
);

    // Lookup and redirect channel between the two halves
    bp_fetch_if fetch_if ();

    fetch_pc_gen pc_gen_unit (
        .clk_i               ( clk_i               ),
        .rst_i               ( rst_i               ),
        .fetch               ( fetch_if            ),
        .credit_i            ( credit_i            ),
        .fetch_valid_o       ( fetch_valid_o       ),
        .fetch_pc_o          ( fetch_pc_o          ),
        .fetch_pred_taken_o  ( fetch_pred_taken_o  ),
        .fetch_pred_target_o ( fetch_pred_target_o )
    );

    branch_predictor predictor_i (
        .clk_i                 ( clk_i                 ),
        .rst_i                 ( rst_i                 ),
        .fetch                 ( fetch_if              ),
        .resolve_valid_i       ( resolve_valid_i       ),
        .resolve_pc_i          ( resolve_pc_i          ),
        .resolve_kind_i        ( resolve_kind_i        ),
        .resolve_taken_i       ( resolve_taken_i       ),
        .resolve_target_i      ( resolve_target_i      ),
        .resolve_pred_taken_i  ( resolve_pred_taken_i  ),
        .resolve_pred_target_i ( resolve_pred_target_i ),
        .mispredict_o          ( mispredict_o          )
    );

    assign redirect_pc_o = fetch_if.redirect_pc;

endmodule

// ==== rtl/predictor_unit.sv ====
module predictor_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [bp_pkg::ADDR_W-1:0] lookup_pc_i,
    bp_update_if.tbl                  upd,
    output logic                      taken_o
);
    import bp_pkg::*;

    // One saturating counter per table slot
    ctr_state_e ctr_q [PHT_ENTRIES];

    logic [PHT_IDX_W-1:0] lk_idx;
    logic [PHT_IDX_W-1:0] upd_idx;
    logic                 train;

    // Move one step toward the outcome and stick at both ends
    function automatic ctr_state_e ctr_step(input ctr_state_e cur, input logic taken);
        ctr_state_e nxt;
        nxt = cur;
        case (cur)
            CTR_STRONG_NT: nxt = taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
            CTR_WEAK_NT:   nxt = taken ? CTR_WEAK_T   : CTR_STRONG_NT;
            CTR_WEAK_T:    nxt = taken ? CTR_STRONG_T : CTR_WEAK_NT;
            CTR_STRONG_T:  nxt = taken ? CTR_STRONG_T : CTR_WEAK_T;
            default:       nxt = CTR_WEAK_NT;
        endcase
        return nxt;
    endfunction

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------

    assign lk_idx = pht_index(lookup_pc_i);

    // Upper half of the encoding means predict taken
    assign taken_o = (ctr_q[lk_idx] == CTR_WEAK_T) || (ctr_q[lk_idx] == CTR_STRONG_T);

    // --------------------------------------------------
    // Training
    // --------------------------------------------------

    // Jumps are always taken, so they never disturb the direction history
    assign upd_idx = pht_index(upd.upd_pc);
    assign train   = upd.upd_valid && (upd.upd_kind == KIND_COND);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (train) begin
            ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd.upd_taken);
        end
    end

    // Each counter must hold one of the four encodings after any training history
    for (genvar g = 0; g < PHT_ENTRIES; g++) begin : g_ctr_chk
        a_ctr_legal: assert property (
            @(posedge clk_i) disable iff (rst_i)
            ctr_q[g] inside {CTR_STRONG_NT, CTR_WEAK_NT, CTR_WEAK_T, CTR_STRONG_T}
        );
    end

endmodule

// ==== src.f ====
rtl/bp_pkg.sv
rtl/bp_fetch_if.sv
rtl/bp_update_if.sv
rtl/branch_target_buffer.sv
rtl/predictor_unit.sv
rtl/branch_predictor.sv
rtl/fetch_pc_gen.sv
rtl/frontend_top.sv
dv/frontend_tb.sv
